/* acq_seq.f */
src/acq_pkg.sv
src/acq_config_regs.sv
src/acq_sequencer.sv
src/acq_sample_capture.sv
src/acq_top.sv
testbench/acq_props.sv
testbench/acq_checker.sv
testbench/tb_acq_top.sv

/* run_sim.sh */
#!/bin/sh
# build the acquisition sequencer testbench with verilator and run it
# exit status is 0 only when the pass message shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_acq_top -f acq_seq.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_acq_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^\*\* PASS \*\*$'; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

/* src/acq_config_regs.sv */
/*
  host-written configuration registers, write-only, no ready
  a write lands on the edge where cfg_valid_i is high
  writes to addresses 6 and 7 are dropped
  entries should only be rewritten while run is low
*/

`timescale 1ns/1ps

module acq_config_regs #(
  parameter int unsigned PRECHARGE_RESET = 8
) (
  input  logic                clk,
  input  logic                reset_n,

  // host write port
  input  logic                cfg_valid_i,
  input  acq_pkg::acq_addr_e  cfg_addr_i,
  input  acq_pkg::acq_wdata_u cfg_wdata_i,

  // configuration record to the sequencer
  output acq_pkg::acq_cfg_t   cfg_o
);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      // dwell comes up at the build-time default, everything else cleared
      cfg_o.precharge_cycles <= acq_pkg::ACQ_CNT_W'(PRECHARGE_RESET);
      cfg_o.seq_last         <= '0;
      cfg_o.run              <= 1'b0;
      cfg_o.entries          <= '0;
    end
    else if (cfg_valid_i)
    begin
      case (cfg_addr_i)
        // whole word is the dwell count
        acq_pkg::ADDR_PRECHARGE:
          cfg_o.precharge_cycles <= cfg_wdata_i.dwell;

        // control view, entry bits ignored here
        acq_pkg::ADDR_CTRL:
        begin
          cfg_o.run      <= cfg_wdata_i.ctrl.run;
          cfg_o.seq_last <= cfg_wdata_i.ctrl.seq_last;
        end

        ////////////////////
        // entry view, only the low six bits matter
        acq_pkg::ADDR_SEQ0:
          cfg_o.entries[0] <= cfg_wdata_i.ctrl.entry;
        acq_pkg::ADDR_SEQ1:
          cfg_o.entries[1] <= cfg_wdata_i.ctrl.entry;
        acq_pkg::ADDR_SEQ2:
          cfg_o.entries[2] <= cfg_wdata_i.ctrl.entry;
        acq_pkg::ADDR_SEQ3:
          cfg_o.entries[3] <= cfg_wdata_i.ctrl.entry;

        // undefined address, nothing changes
        default:
        begin
        end
      endcase
    end
  end

endmodule

/* src/acq_pkg.sv */
/*
  shared types of the auto-zero acquisition sequencer
  the write word is read as a dwell count or as a control/entry word,
  and the register address picks which view applies
*/

package acq_pkg;

  ////////////////////
  // sizes

  // number of sequence slots
  localparam int ACQ_SEQ_MAX = 4;
  // width of one adc conversion result
  localparam int ACQ_DATA_W  = 24;
  // width of the dwell down-counter and of the dwell register
  localparam int ACQ_CNT_W   = 24;
  // width of the sample index within a sequence
  localparam int ACQ_IDX_W   = $clog2(ACQ_SEQ_MAX);

  ////////////////////
  // sequence entry and configuration

  // one sequence slot, precharge switch code above the input-mux code
  typedef struct packed {
    logic [1:0] pc_sw;
    logic [3:0] azmux;
  } acq_entry_t;

  // whole configuration as seen by the sequencer
  typedef struct packed {
    logic [ACQ_CNT_W-1:0]                precharge_cycles;
    logic [ACQ_IDX_W-1:0]                seq_last;
    logic                                run;
    acq_entry_t [ACQ_SEQ_MAX-1:0]        entries;
  } acq_cfg_t;

  ////////////////////
  // host write word

  // control or entry view; run/seq_last only matter on the ctrl address
  typedef struct packed {
    logic [ACQ_CNT_W-ACQ_IDX_W-$bits(acq_entry_t)-2:0] unused;
    logic                                            run;
    logic [ACQ_IDX_W-1:0]                            seq_last;
    acq_entry_t                                      entry;
  } acq_ctrl_word_t;

  // same 24 bits, two decodings
  typedef union packed {
    logic [ACQ_CNT_W-1:0] dwell;
    acq_ctrl_word_t       ctrl;
  } acq_wdata_u;

  // register map
  typedef enum logic [2:0] {
    ADDR_PRECHARGE = 3'd0,
    ADDR_CTRL      = 3'd1,
    ADDR_SEQ0      = 3'd2,
    ADDR_SEQ1      = 3'd3,
    ADDR_SEQ2      = 3'd4,
    ADDR_SEQ3      = 3'd5
  } acq_addr_e;

  ////////////////////
  // result record handed to the reader
  typedef struct packed {
    logic [ACQ_DATA_W-1:0] data;
    logic [ACQ_IDX_W-1:0]  index;
    logic [3:0]            azmux;
  } acq_result_t;

endpackage

/* src/acq_sample_capture.sv */
/*
  one-entry result register with a valid/ready output
  data_i is taken on the load cycle, which is one or more cycles after
  the adc valid pulse, so the adc must keep its last result on adc_data_i
  until it is released again
*/

`timescale 1ns/1ps

module acq_sample_capture (
  input  logic                               clk,
  input  logic                               reset_n,

  // load side from the sequencer
  input  logic                               load_i,
  input  logic [acq_pkg::ACQ_DATA_W-1:0]     data_i,
  input  logic [acq_pkg::ACQ_IDX_W-1:0]      index_i,
  input  logic [3:0]                         azmux_i,
  output logic                               room_o,

  // result port
  output acq_pkg::acq_result_t               res_o,
  output logic                               res_valid_o,
  input  logic                               res_ready_i
);

  // free now, or freed by a read in this same cycle
  assign room_o = !res_valid_o || res_ready_i;

  ////////////////////
  // occupancy
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      res_valid_o <= 1'b0;
    else if (load_i)
      // a load on the read cycle replaces the leaving result
      res_valid_o <= 1'b1;
    else if (res_ready_i)
      res_valid_o <= 1'b0;
  end

  ////////////////////
  // payload, held steady until the next load
  always_ff @(posedge clk)
  begin
    if (load_i)
    begin
      res_o.data  <= data_i;
      res_o.index <= index_i;
      res_o.azmux <= azmux_i;
    end
  end

endmodule

/* src/acq_sequencer.sv */
/*
  phase FSM per sample: park, mux, switch (each P+1 cycles), then measure
  pc_sw and azmux only move while the adc is held in reset
  run low stops at the next dwell boundary; a released conversion always finishes
  each run starts at slot 0
*/

`timescale 1ns/1ps

module acq_sequencer (
  input  logic                               clk,
  input  logic                               reset_n,

  // configuration from the register block
  input  acq_pkg::acq_cfg_t                  cfg_i,

  // adc side
  input  logic                               adc_valid_i,
  output logic                               adc_reset_n_o,
  output logic [1:0]                         pc_sw_o,
  output logic [3:0]                         azmux_o,

  // capture stage side
  input  logic                               cap_room_i,
  output logic                               cap_load_o,
  output logic [acq_pkg::ACQ_IDX_W-1:0]      cap_index_o,
  output logic [3:0]                         cap_azmux_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PARK,
    ST_MUX,
    ST_SWITCH,
    ST_MEASURE,
    ST_WAIT
  } state_t;

  state_t                          state;
  logic [acq_pkg::ACQ_CNT_W-1:0]   dwell_cnt;
  logic [acq_pkg::ACQ_IDX_W-1:0]   index;
  acq_pkg::acq_entry_t             entry;
  logic                            dwell_done;
  logic                            last_slot;

  // slot for the sample in progress
  assign entry      = cfg_i.entries[index];
  assign dwell_done = (dwell_cnt == '0);
  // >= so a shortened sequence cannot strand the index past the end
  assign last_slot  = (index >= cfg_i.seq_last);

  ////////////////////
  // capture handshake
  // load only from the wait state and only when the capture register can take it
  assign cap_load_o  = (state == ST_WAIT) && cap_room_i;
  assign cap_index_o = index;
  // mux code is still the one used for this conversion
  assign cap_azmux_o = azmux_o;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      state         <= ST_IDLE;
      dwell_cnt     <= '0;
      index         <= '0;
      adc_reset_n_o <= 1'b0;
      pc_sw_o       <= 2'b00;
      azmux_o       <= 4'h0;
    end
    else
    begin
      case (state)
        // waiting for run, adc held in reset
        ST_IDLE:
        begin
          if (cfg_i.run)
          begin
            state     <= ST_PARK;
            // park precharge switch at boot before touching the mux
            pc_sw_o   <= 2'b00;
            dwell_cnt <= cfg_i.precharge_cycles;
          end
        end

        ////////////////////
        // the three dwell phases share the counter
        ST_PARK, ST_MUX, ST_SWITCH:
        begin
          if (!dwell_done)
            dwell_cnt <= dwell_cnt - 1'b1;
          else if (!cfg_i.run)
          begin
            // abandon before release, no conversion was started
            state   <= ST_IDLE;
            index   <= '0;
            pc_sw_o <= 2'b00;
          end
          else
          begin
            dwell_cnt <= cfg_i.precharge_cycles;
            case (state)
              // park done, select the input of interest
              ST_PARK:
              begin
                state   <= ST_MUX;
                azmux_o <= entry.azmux;
              end
              // mux settled, move precharge switch off boot
              ST_MUX:
              begin
                state   <= ST_SWITCH;
                pc_sw_o <= entry.pc_sw;
              end
              // everything settled, let the adc run
              default:
              begin
                state         <= ST_MEASURE;
                adc_reset_n_o <= 1'b1;
              end
            endcase
          end
        end

        // adc decides when it is done
        ST_MEASURE:
        begin
          if (adc_valid_i)
          begin
            state         <= ST_WAIT;
            // back into reset at once, the data stays on the adc output
            adc_reset_n_o <= 1'b0;
          end
        end

        ////////////////////
        // hand the result over, stall here while the reader is slow
        ST_WAIT:
        begin
          if (cap_room_i)
          begin
            if (cfg_i.run)
            begin
              state     <= ST_PARK;
              pc_sw_o   <= 2'b00;
              dwell_cnt <= cfg_i.precharge_cycles;
              if (last_slot)
                index <= '0;
              else
                index <= index + 1'b1;
            end
            else
            begin
              state   <= ST_IDLE;
              index   <= '0;
              pc_sw_o <= 2'b00;
            end
          end
        end

        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* src/acq_top.sv */
/*
  acquisition sequencer top: config registers, phase FSM, result register
  with no back-pressure a result is valid two cycles after adc_valid_i
  adc_data_i must hold the last conversion until the adc is released again
*/

`timescale 1ns/1ps

module acq_top #(
  parameter int unsigned PRECHARGE_RESET = 8
) (
  input  logic                               clk,
  input  logic                               reset_n,

  // host write port, valid only
  input  logic                               cfg_valid_i,
  input  acq_pkg::acq_addr_e                 cfg_addr_i,
  input  acq_pkg::acq_wdata_u                cfg_wdata_i,

  // adc and analog switches
  input  logic                               adc_valid_i,
  input  logic [acq_pkg::ACQ_DATA_W-1:0]     adc_data_i,
  output logic                               adc_reset_n_o,
  output logic [1:0]                         pc_sw_o,
  output logic [3:0]                         azmux_o,

  // result port
  output acq_pkg::acq_result_t               res_o,
  output logic                               res_valid_o,
  input  logic                               res_ready_i
);

  acq_pkg::acq_cfg_t                 cfg;
  logic                              cap_room;
  logic                              cap_load;
  logic [acq_pkg::ACQ_IDX_W-1:0]     cap_index;
  logic [3:0]                        cap_azmux;

  // host side registers
  acq_config_regs #(
    .PRECHARGE_RESET (PRECHARGE_RESET)
  ) u_regs (
    .clk         (clk),
    .reset_n     (reset_n),
    .cfg_valid_i (cfg_valid_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_o       (cfg)
  );

  // phase FSM, owns the switches and the adc reset
  acq_sequencer u_seq (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_i         (cfg),
    .adc_valid_i   (adc_valid_i),
    .adc_reset_n_o (adc_reset_n_o),
    .pc_sw_o       (pc_sw_o),
    .azmux_o       (azmux_o),
    .cap_room_i    (cap_room),
    .cap_load_o    (cap_load),
    .cap_index_o   (cap_index),
    .cap_azmux_o   (cap_azmux)
  );

  // result record toward the reader
  acq_sample_capture u_cap (
    .clk         (clk),
    .reset_n     (reset_n),
    .load_i      (cap_load),
    .data_i      (adc_data_i),
    .index_i     (cap_index),
    .azmux_i     (cap_azmux),
    .room_o      (cap_room),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
  );

endmodule

/* testbench/acq_checker.sv */
/*
  scoreboard for the acquisition sequencer, samples the ports on the rising edge
  expected values come from the test context that the testbench drives
  assumes run is cleared before the next release once a test has its results
*/

`timescale 1ns/1ps

module acq_checker (
  input  logic                      clk,
  input  logic                      reset_n,

  // dut outputs, plus the ready the dut sees
  input  logic                      adc_reset_n_i,
  input  logic [1:0]                pc_sw_i,
  input  logic [3:0]                azmux_i,
  input  acq_pkg::acq_result_t      res_i,
  input  logic                      res_valid_i,
  input  logic                      res_ready_i,

  // test context
  input  logic                      test_start_i,
  input  logic                      test_end_i,
  input  logic                      quiet_i,
  input  int                        test_id_i,
  input  logic [23:0]               dwell_i,
  input  logic [1:0]                seq_last_i,
  input  acq_pkg::acq_entry_t [3:0] entries_i,

  // counts
  output int                        res_seen_o,
  output int                        err_total_o,
  output int                        res_total_o,
  output int                        tests_done_o
);

  int                   res_seen = 0;
  int                   err_total = 0;
  int                   res_total = 0;
  int                   tests_done = 0;
  int                   test_errs = 0;
  // phase tracking, all counted while the adc is in reset
  int                   low_cnt = 0;
  int                   stable_cnt = 0;
  int                   zero_cnt = 0;
  int                   zero_run = 0;
  int                   p1;
  logic                 adc_prev = 1'b0;
  logic [5:0]           sw_prev = '0;
  logic                 reset_prev = 1'b0;
  logic                 hold_pending = 1'b0;
  acq_pkg::acq_result_t held = '0;
  // next expected slot at release and at the result port
  logic [1:0]           rel_idx = '0;
  logic [1:0]           res_idx = '0;

  assign res_seen_o   = res_seen;
  assign err_total_o  = err_total;
  assign res_total_o  = res_total;
  assign tests_done_o = tests_done;
  assign p1           = int'(dwell_i) + 1;

  // adc model rule, one fixed code per mux input
  function automatic logic [23:0] expected_data(input logic [3:0] mux);
    return ({20'd0, mux} * 24'h111111) ^ 24'hA5A5A5;
  endfunction

  task automatic value_error(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    $display("ERR %s expected 0x%h actual 0x%h (test %0d)", name, exp_v, act_v, test_id_i);
    test_errs++;
    err_total++;
  endtask

  task automatic fault(input string what);
    $display("test %0d: %s at %0t", test_id_i, what, $time);
    test_errs++;
    err_total++;
  endtask

  ////////////////////
  // adc release, checks the three dwell phases before it
  task automatic check_release();
    acq_pkg::acq_entry_t e;
    e = entries_i[rel_idx];
    if (quiet_i)
      fault("adc released although run was cleared");
    else
    begin
      if (pc_sw_i != e.pc_sw)
        value_error("pc_sw_o", 24'(e.pc_sw), 24'(pc_sw_i));
      if (azmux_i != e.azmux)
        value_error("azmux_o", 24'(e.azmux), 24'(azmux_i));
      if (stable_cnt < p1)
        fault("switch phase shorter than the dwell");
      if (low_cnt < 3 * p1)
        fault("adc released before three dwell phases");
      // pc_sw of 0 merges park, mux and switch into one zero stretch
      if ((e.pc_sw != 2'b00) ? (zero_run < 2 * p1) : (zero_cnt < 3 * p1))
        fault("pc_sw not parked at 0 long enough");
      rel_idx = (rel_idx == seq_last_i) ? 2'd0 : rel_idx + 2'd1;
    end
  endtask

  ////////////////////
  // one transfer on the result port
  task automatic check_result();
    acq_pkg::acq_entry_t e;
    e = entries_i[res_idx];
    if (quiet_i)
      fault("result appeared although run was cleared");
    else
    begin
      if (res_i.index != res_idx)
        value_error("res_o.index", 24'(res_idx), 24'(res_i.index));
      if (res_i.azmux != e.azmux)
        value_error("res_o.azmux", 24'(e.azmux), 24'(res_i.azmux));
      if (res_i.data != expected_data(e.azmux))
        value_error("res_o.data", expected_data(e.azmux), res_i.data);
      res_idx = (res_idx == seq_last_i) ? 2'd0 : res_idx + 2'd1;
    end
    res_seen++;
    res_total++;
  endtask

  // outputs one edge after a reset edge
  task automatic check_reset_values();
    if (adc_reset_n_i != 1'b0)
      value_error("adc_reset_n_o", 24'h0, 24'(adc_reset_n_i));
    if (res_valid_i != 1'b0)
      value_error("res_valid_o", 24'h0, 24'(res_valid_i));
    if (pc_sw_i != 2'b00)
      value_error("pc_sw_o", 24'h0, 24'(pc_sw_i));
    if (azmux_i != 4'h0)
      value_error("azmux_o", 24'h0, 24'(azmux_i));
  endtask

  always @(posedge clk)
  begin
    if (test_start_i)
    begin
      res_seen  = 0;
      test_errs = 0;
      rel_idx   = '0;
      res_idx   = '0;
    end
    if (reset_prev)
      check_reset_values();
    reset_prev = !reset_n;

    if (!reset_n)
    begin
      hold_pending = 1'b0;
      rel_idx      = '0;
      res_idx      = '0;
      low_cnt      = 0;
      stable_cnt   = 0;
      zero_cnt     = 0;
      zero_run     = 0;
    end
    else
    begin
      ////////////////////
      // phase tracking
      if (adc_reset_n_i)
      begin
        if (!adc_prev)
          check_release();
        low_cnt    = 0;
        stable_cnt = 0;
        zero_cnt   = 0;
        zero_run   = 0;
      end
      else
      begin
        low_cnt++;
        if ({pc_sw_i, azmux_i} == sw_prev)
          stable_cnt++;
        else
          stable_cnt = 1;
        if (pc_sw_i == 2'b00)
          zero_cnt++;
        else if (zero_cnt != 0)
        begin
          // pc_sw just left 0, keep the length of that stretch
          zero_run = zero_cnt;
          zero_cnt = 0;
        end
      end

      ////////////////////
      // result port, a waiting result must not move
      if (hold_pending)
      begin
        if (!res_valid_i)
          fault("res_valid_o dropped before res_ready_i");
        else if (res_i != held)
          value_error("res_o", 32'(held), 32'(res_i));
      end
      if (res_valid_i && res_ready_i)
        check_result();
      hold_pending = res_valid_i && !res_ready_i;
      held         = res_i;
    end

    adc_prev = adc_reset_n_i;
    sw_prev  = {pc_sw_i, azmux_i};

    if (test_end_i)
    begin
      $display("test %0d: %0d results, %0d errors, %s", test_id_i, res_seen, test_errs,
               (test_errs == 0) ? "ok" : "bad");
      tests_done++;
    end
  end

endmodule

/* testbench/acq_props.sv */
/*
  concurrent checks on the sequencer, attached by bind from the testbench
  fail_cnt counts assertion failures so the testbench can see them
*/

`timescale 1ns/1ps

module acq_props (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       adc_valid_i,
  input  logic       adc_reset_n_i,
  input  logic [1:0] pc_sw_i,
  input  logic [3:0] azmux_i,
  input  logic       cap_room_i,
  input  logic       cap_load_i
);

  int fail_cnt = 0;

  // analog switches frozen while the adc converts
  switches_frozen: assert property (@(posedge clk) disable iff (!reset_n)
    $past(adc_reset_n_i) |-> ($stable(pc_sw_i) && $stable(azmux_i)))
  else
  begin
    $error("pc_sw or azmux moved while the adc was released");
    fail_cnt++;
  end

  // result loaded right after the valid pulse, held back while the capture register is full
  load_waits_for_room: assert property (@(posedge clk) disable iff (!reset_n)
    (adc_valid_i && adc_reset_n_i) |=> (cap_load_i == cap_room_i))
  else
  begin
    $error("cap_load did not follow cap_room in the cycle after adc_valid");
    fail_cnt++;
  end

  // adc back in reset right after its valid pulse
  reset_after_valid: assert property (@(posedge clk) disable iff (!reset_n)
    (adc_valid_i && adc_reset_n_i) |=> !adc_reset_n_i)
  else
  begin
    $error("adc still released in the cycle after adc_valid");
    fail_cnt++;
  end

endmodule

/* testbench/tb_acq_top.sv */
/*
  testbench for acq_top: clock, reset, adc model, stimulus table, watchdog
  the adc model keeps its last code on adc_data until it is released again
  the final test resets the dut in the middle of a conversion
*/

`timescale 1ns/1ps

module tb_acq_top;

  localparam int NUM_TESTS = 5;
  localparam int CLK_HALF  = 20;
  // config writes, quiet windows and the reset test
  localparam int MARGIN    = 1500;

  typedef struct packed {
    logic [23:0]               dwell;
    logic [1:0]                seq_last;
    acq_pkg::acq_entry_t [3:0] entries;
    logic [7:0]                n_results;
    logic                      slow_ready;
  } test_vec_t;

  logic                 clk;
  logic                 reset_n;
  logic                 cfg_valid;
  acq_pkg::acq_addr_e   cfg_addr;
  acq_pkg::acq_wdata_u  cfg_wdata;
  logic                 adc_valid = 1'b0;
  logic [23:0]          adc_data = '0;
  logic                 adc_reset_n;
  logic [1:0]           pc_sw;
  logic [3:0]           azmux;
  acq_pkg::acq_result_t res;
  logic                 res_valid;
  logic                 res_ready = 1'b0;

  // test context for the checker
  logic                 test_start;
  logic                 test_end;
  logic                 quiet;
  int                   test_id;
  test_vec_t            tests [NUM_TESTS];
  test_vec_t            cur = '0;
  int                   res_seen;
  int                   err_total;
  int                   res_total;
  int                   tests_done;

  // adc model state
  int                   adc_wait = 0;
  logic                 adc_armed = 1'b0;
  logic                 adc_answered = 1'b0;
  int                   cyc = 0;

  acq_top #(
    .PRECHARGE_RESET (8)
  ) dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .cfg_valid_i   (cfg_valid),
    .cfg_addr_i    (cfg_addr),
    .cfg_wdata_i   (cfg_wdata),
    .adc_valid_i   (adc_valid),
    .adc_data_i    (adc_data),
    .adc_reset_n_o (adc_reset_n),
    .pc_sw_o       (pc_sw),
    .azmux_o       (azmux),
    .res_o         (res),
    .res_valid_o   (res_valid),
    .res_ready_i   (res_ready)
  );

  acq_checker u_chk (
    .clk           (clk),
    .reset_n       (reset_n),
    .adc_reset_n_i (adc_reset_n),
    .pc_sw_i       (pc_sw),
    .azmux_i       (azmux),
    .res_i         (res),
    .res_valid_i   (res_valid),
    .res_ready_i   (res_ready),
    .test_start_i  (test_start),
    .test_end_i    (test_end),
    .quiet_i       (quiet),
    .test_id_i     (test_id),
    .dwell_i       (cur.dwell),
    .seq_last_i    (cur.seq_last),
    .entries_i     (cur.entries),
    .res_seen_o    (res_seen),
    .err_total_o   (err_total),
    .res_total_o   (res_total),
    .tests_done_o  (tests_done)
  );

  bind acq_sequencer acq_props u_props (
    .clk           (clk),
    .reset_n       (reset_n),
    .adc_valid_i   (adc_valid_i),
    .adc_reset_n_i (adc_reset_n_o),
    .pc_sw_i       (pc_sw_o),
    .azmux_i       (azmux_o),
    .cap_room_i    (cap_room_i),
    .cap_load_i    (cap_load_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  ////////////////////
  // adc model, answers 3 to 20 cycles after release
  always @(negedge clk)
  begin
    adc_valid = 1'b0;
    if (!adc_reset_n)
    begin
      adc_armed    = 1'b0;
      adc_answered = 1'b0;
    end
    else if (!adc_armed)
    begin
      adc_armed = 1'b1;
      adc_wait  = 1 + int'($urandom % 18);
    end
    else if (!adc_answered)
    begin
      if (adc_wait == 0)
      begin
        adc_valid    = 1'b1;
        adc_data     = ({20'd0, azmux} * 24'h111111) ^ 24'hA5A5A5;
        adc_answered = 1'b1;
      end
      else
        adc_wait--;
    end
  end

  // reader, always ready or ready one cycle in four
  always @(negedge clk)
  begin
    cyc++;
    res_ready = cur.slow_ready ? (cyc % 4 == 0) : 1'b1;
  end

  function automatic acq_pkg::acq_entry_t make_entry(input logic [1:0] sw,
                                                     input logic [3:0] mux);
    acq_pkg::acq_entry_t e;
    e.pc_sw = sw;
    e.azmux = mux;
    return e;
  endfunction

  // columns: dwell, seq_last, entries slot 3 down to 0, results, slow reader
  task automatic fill_table();
    tests[0] = '{24'd2, 2'd0, {make_entry(0, 0), make_entry(0, 0), make_entry(0, 0),
                 make_entry(1, 3)}, 8'd3, 1'b0};
    tests[1] = '{24'd3, 2'd1, {make_entry(0, 0), make_entry(0, 0), make_entry(0, 9),
                 make_entry(2, 5)}, 8'd5, 1'b0};
    tests[2] = '{24'd2, 2'd3, {make_entry(0, 0), make_entry(3, 12), make_entry(2, 7),
                 make_entry(1, 1)}, 8'd9, 1'b0};
    tests[3] = '{24'd4, 2'd3, {make_entry(1, 2), make_entry(2, 10), make_entry(1, 6),
                 make_entry(3, 15)}, 8'd8, 1'b1};
    tests[4] = '{24'd2, 2'd1, {make_entry(0, 0), make_entry(0, 0), make_entry(2, 8),
                 make_entry(1, 4)}, 8'd6, 1'b1};
  endtask

  ////////////////////
  // host writes, one per cycle from a falling edge
  task automatic write_reg(input acq_pkg::acq_addr_e addr, input acq_pkg::acq_wdata_u wd);
    cfg_valid = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = wd;
    @(negedge clk);
    cfg_valid = 1'b0;
  endtask

  task automatic set_ctrl(input logic [1:0] last, input logic run);
    acq_pkg::acq_wdata_u wd;
    wd               = '0;
    wd.ctrl.seq_last = last;
    wd.ctrl.run      = run;
    write_reg(acq_pkg::ADDR_CTRL, wd);
  endtask

  // everything with run low
  task automatic write_config(input test_vec_t v);
    acq_pkg::acq_wdata_u wd;
    int i;
    wd       = '0;
    wd.dwell = v.dwell;
    write_reg(acq_pkg::ADDR_PRECHARGE, wd);
    for (i = 0; i < 4; i++)
    begin
      wd            = '0;
      wd.ctrl.entry = v.entries[i];
      write_reg(acq_pkg::acq_addr_e'(3'(int'(acq_pkg::ADDR_SEQ0) + i)), wd);
    end
    set_ctrl(v.seq_last, 1'b0);
  endtask

  task automatic begin_test(input int t);
    test_id    = t;
    quiet      = 1'b0;
    test_start = 1'b1;
    @(negedge clk);
    test_start = 1'b0;
  endtask

  task automatic end_test();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  task automatic run_test(input int t);
    cur = tests[t];
    write_config(cur);
    begin_test(t);
    set_ctrl(cur.seq_last, 1'b1);
    while (res_seen < int'(cur.n_results))
      @(negedge clk);
    // stop before the next release, then watch for stray activity
    quiet = 1'b1;
    set_ctrl(cur.seq_last, 1'b0);
    repeat (3 * (int'(cur.dwell) + 1) + 40) @(negedge clk);
    end_test();
  endtask

  // reset in the middle of a conversion
  task automatic reset_test();
    cur = tests[0];
    write_config(cur);
    begin_test(NUM_TESTS);
    set_ctrl(cur.seq_last, 1'b1);
    while (!adc_reset_n)
      @(negedge clk);
    quiet   = 1'b1;
    reset_n = 1'b0;
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    repeat (20) @(negedge clk);
    end_test();
  endtask

  ////////////////////
  // main sequence
  initial
  begin
    void'($urandom(32245));
    reset_n    = 1'b0;
    cfg_valid  = 1'b0;
    cfg_addr   = acq_pkg::ADDR_PRECHARGE;
    cfg_wdata  = '0;
    test_start = 1'b0;
    test_end   = 1'b0;
    quiet      = 1'b1;
    test_id    = 0;
    fill_table();
    repeat (10) @(negedge clk);
    reset_n = 1'b1;
    repeat (2) @(negedge clk);
    for (int t = 0; t < NUM_TESTS; t++)
      run_test(t);
    reset_test();
    $display("tests %0d, results %0d, checker errors %0d, assertion failures %0d",
             tests_done, res_total, err_total, dut.u_seq.u_props.fail_cnt);
    if (err_total == 0 && dut.u_seq.u_props.fail_cnt == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // watchdog sized from the table
  initial
  begin : watchdog
    int limit;
    int t;
    @(posedge reset_n);
    limit = MARGIN;
    for (t = 0; t < NUM_TESTS; t++)
      limit += int'(tests[t].n_results) * (3 * (int'(tests[t].dwell) + 1) + 30);
    repeat (limit) @(posedge clk);
    $display("watchdog: tests did not finish within %0d cycles, results stopped arriving",
             limit);
    $display("** FAIL **");
    $finish;
  end

endmodule
